//--- include/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// datapath and register file sizes
`define MIPS_XLEN       32
`define MIPS_NREG       32
`define MIPS_RADDR_W    5

// first fetch address out of reset
`define MIPS_RESET_PC   32'h0000_0000

// instruction field ranges
`define MIPS_F_OP       31:26
`define MIPS_F_RS       25:21
`define MIPS_F_RT       20:16
`define MIPS_F_RD       15:11
`define MIPS_F_FUNCT    5:0
`define MIPS_F_IMM      15:0

`endif

//--- source/mips_isa_pkg.sv
`include "mips_defines.svh"

package mips_isa_pkg;

    typedef logic [`MIPS_XLEN-1:0]    word_t;
    typedef logic [`MIPS_RADDR_W-1:0] regAddr_t;
    typedef logic [5:0]               opcode_t;
    typedef logic [5:0]               funct_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } aluOp_e;

    // major opcodes
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    // special function codes
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_SLT  = 6'h2a;

endpackage

//--- source/mips_pipe_pkg.sv
package mips_pipe_pkg;

    import mips_isa_pkg::*;

    // decoded control bundle
    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   aluSrcImm;
        logic   zeroExtend;
        logic   regDstRd;
        logic   branch;
        aluOp_e aluOp;
    } ctrl_t;

    // operand source for execute
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwdSel_e;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    pc;
        word_t    opA;
        word_t    opB;
        word_t    imm;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t dest;
    } idEx_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    pc;
        word_t    aluRes;
        word_t    storeData;
        regAddr_t dest;
    } exMem_t;

    // only what write-back still needs
    typedef struct packed {
        logic     regWrite;
        logic     memRead;
        word_t    pc;
        word_t    aluRes;
        regAddr_t dest;
    } memWb_t;

endpackage

//--- source/instrDecoder.sv
`timescale 1ns/1ps

`include "mips_defines.svh"

module instrDecoder (
    input  mips_isa_pkg::word_t    instr_i,
    output mips_pipe_pkg::ctrl_t   ctrl_o,
    output mips_isa_pkg::regAddr_t rs_o,
    output mips_isa_pkg::regAddr_t rt_o,
    output mips_isa_pkg::regAddr_t dest_o
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    opcode_t  opcode;
    funct_t   funct;
    regAddr_t rd;

    assign opcode = instr_i[`MIPS_F_OP];
    assign funct  = instr_i[`MIPS_F_FUNCT];
    assign rs_o   = instr_i[`MIPS_F_RS];
    assign rt_o   = instr_i[`MIPS_F_RT];
    assign rd     = instr_i[`MIPS_F_RD];

    always_comb begin
        ctrl_o       = '0;
        ctrl_o.aluOp = ALU_ADD;
        case (opcode)
            OP_RTYPE: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.regDstRd = 1'b1;
                case (funct)
                    FN_ADDU: ctrl_o.aluOp = ALU_ADD;
                    FN_SUBU: ctrl_o.aluOp = ALU_SUB;
                    FN_AND:  ctrl_o.aluOp = ALU_AND;
                    FN_OR:   ctrl_o.aluOp = ALU_OR;
                    FN_SLT:  ctrl_o.aluOp = ALU_SLT;
                    // unsupported funct acts as a nop
                    default: ctrl_o.regWrite = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
            end
            OP_ORI: begin
                ctrl_o.regWrite   = 1'b1;
                ctrl_o.aluSrcImm  = 1'b1;
                ctrl_o.zeroExtend = 1'b1;
                ctrl_o.aluOp      = ALU_OR;
            end
            OP_LW: begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.memRead   = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
            end
            OP_SW: begin
                ctrl_o.memWrite  = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
            end
            OP_BEQ: ctrl_o.branch = 1'b1;
            default: ;
        endcase

        dest_o = ctrl_o.regDstRd ? rd : rt_o;
        // $zero is never a real destination
        if (dest_o == '0) begin
            ctrl_o.regWrite = 1'b0;
        end
    end

endmodule

//--- source/regFile.sv
`timescale 1ns/1ps

`include "mips_defines.svh"

module regFile (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  mips_isa_pkg::regAddr_t readAddrA_i,
    input  mips_isa_pkg::regAddr_t readAddrB_i,
    input  logic                   writeEn_i,
    input  mips_isa_pkg::regAddr_t writeAddr_i,
    input  mips_isa_pkg::word_t    writeData_i,
    output mips_isa_pkg::word_t    readDataA_o,
    output mips_isa_pkg::word_t    readDataB_o
);
    import mips_isa_pkg::*;

    word_t regs [`MIPS_NREG];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `MIPS_NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn_i) begin
            regs[writeAddr_i] <= writeData_i;
        end
    end

    // write in the same cycle wins over the stored value
    function automatic word_t readPort(input regAddr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (writeEn_i && writeAddr_i == addr) begin
            return writeData_i;
        end
        return regs[addr];
    endfunction

    always_comb begin
        readDataA_o = readPort(readAddrA_i);
        readDataB_o = readPort(readAddrB_i);
    end

endmodule

//--- source/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input  mips_isa_pkg::word_t  a_i,
    input  mips_isa_pkg::word_t  b_i,
    input  mips_isa_pkg::aluOp_e op_i,
    output mips_isa_pkg::word_t  result_o
);
    import mips_isa_pkg::*;

    logic lessThan;

    // signed compare for slt
    assign lessThan = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            ALU_ADD: result_o = a_i + b_i;
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_SLT: result_o = word_t'(lessThan);
            default: result_o = '0;
        endcase
    end

endmodule

//--- source/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
    input  mips_isa_pkg::regAddr_t rsD_i,
    input  mips_isa_pkg::regAddr_t rtD_i,
    input  logic                   branchD_i,
    input  mips_pipe_pkg::idEx_t   idEx_i,
    input  mips_pipe_pkg::exMem_t  exMem_i,
    input  mips_pipe_pkg::memWb_t  memWb_i,
    output mips_pipe_pkg::fwdSel_e fwdA_o,
    output mips_pipe_pkg::fwdSel_e fwdB_o,
    output logic                   fwdBrA_o,
    output logic                   fwdBrB_o,
    output logic                   stall_o
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    logic exUsedByD;
    logic memUsedByD;
    logic loadUse;
    logic branchWait;

    // memory stage is younger, so it is checked first
    function automatic fwdSel_e pickFwd(input regAddr_t src, input exMem_t em,
                                        input memWb_t mw);
        if (em.ctrl.regWrite && em.dest == src) begin
            return FWD_MEM;
        end
        if (mw.regWrite && mw.dest == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    always_comb begin
        fwdA_o = pickFwd(idEx_i.rs, exMem_i, memWb_i);
        fwdB_o = pickFwd(idEx_i.rt, exMem_i, memWb_i);
    end

    // branch compare can take alu results from memory, not load data
    assign fwdBrA_o = exMem_i.ctrl.regWrite && !exMem_i.ctrl.memRead
                      && exMem_i.dest == rsD_i;
    assign fwdBrB_o = exMem_i.ctrl.regWrite && !exMem_i.ctrl.memRead
                      && exMem_i.dest == rtD_i;

    assign exUsedByD  = idEx_i.ctrl.regWrite
                        && (idEx_i.dest == rsD_i || idEx_i.dest == rtD_i);
    assign memUsedByD = exMem_i.ctrl.regWrite
                        && (exMem_i.dest == rsD_i || exMem_i.dest == rtD_i);

    assign loadUse    = idEx_i.ctrl.memRead && exUsedByD;
    // load data reaches decode only through the register file bypass
    assign branchWait = branchD_i && (exUsedByD || (exMem_i.ctrl.memRead && memUsedByD));

    assign stall_o = loadUse || branchWait;

endmodule

//--- source/mipsCore.sv
`timescale 1ns/1ps

`include "mips_defines.svh"

module mipsCore (
    input  logic                   clk_i,
    input  logic                   rst_i,
    output mips_isa_pkg::word_t    instrAddr_o,
    input  mips_isa_pkg::word_t    instr_i,
    output logic                   dataEn_o,
    output logic                   dataWe_o,
    output mips_isa_pkg::word_t    dataAddr_o,
    output mips_isa_pkg::word_t    dataWdata_o,
    input  mips_isa_pkg::word_t    dataRdata_i,
    output logic                   wbEn_o,
    output mips_isa_pkg::regAddr_t wbReg_o,
    output mips_isa_pkg::word_t    wbData_o,
    output mips_isa_pkg::word_t    wbPc_o
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    word_t    pcF;
    word_t    pcD;
    word_t    instrD;
    ctrl_t    ctrlD;
    regAddr_t rsD;
    regAddr_t rtD;
    regAddr_t destD;
    word_t    rdA;
    word_t    rdB;
    word_t    immD;
    word_t    brA;
    word_t    brB;
    word_t    branchTarget;
    logic     takenD;
    logic     stall;
    fwdSel_e  fwdA;
    fwdSel_e  fwdB;
    logic     fwdBrA;
    logic     fwdBrB;
    idEx_t    idEx;
    exMem_t   exMem;
    memWb_t   memWb;
    word_t    opA;
    word_t    opB;
    word_t    aluB;
    word_t    aluRes;
    word_t    wbData;

    // fetch
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pcF <= `MIPS_RESET_PC;
        end else if (!stall) begin
            pcF <= takenD ? branchTarget : pcF + 32'd4;
        end
    end

    assign instrAddr_o = pcF;

    // fetch/decode register, cleared instr decodes as nop
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            instrD <= '0;
        end else if (!stall) begin
            instrD <= instr_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall) begin
            pcD <= pcF;
        end
    end

    // decode
    instrDecoder i_instrDecoder (
        .instr_i (instrD),
        .ctrl_o  (ctrlD),
        .rs_o    (rsD),
        .rt_o    (rtD),
        .dest_o  (destD)
    );

    regFile i_regFile (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .readAddrA_i (rsD),
        .readAddrB_i (rtD),
        .writeEn_i   (memWb.regWrite),
        .writeAddr_i (memWb.dest),
        .writeData_i (wbData),
        .readDataA_o (rdA),
        .readDataB_o (rdB)
    );

    assign immD = ctrlD.zeroExtend ? {16'b0, instrD[`MIPS_F_IMM]}
                                   : {{16{instrD[15]}}, instrD[`MIPS_F_IMM]};

    // beq resolves here, the delay slot is already in fetch
    assign brA          = fwdBrA ? exMem.aluRes : rdA;
    assign brB          = fwdBrB ? exMem.aluRes : rdB;
    assign takenD       = ctrlD.branch && (brA == brB);
    assign branchTarget = pcD + 32'd4 + {immD[29:0], 2'b00};

    hazardUnit i_hazardUnit (
        .rsD_i     (rsD),
        .rtD_i     (rtD),
        .branchD_i (ctrlD.branch),
        .idEx_i    (idEx),
        .exMem_i   (exMem),
        .memWb_i   (memWb),
        .fwdA_o    (fwdA),
        .fwdB_o    (fwdB),
        .fwdBrA_o  (fwdBrA),
        .fwdBrB_o  (fwdBrB),
        .stall_o   (stall)
    );

    // stall turns the execute slot into a bubble
    always_ff @(posedge clk_i) begin
        idEx <= '{ctrl: ctrlD, pc: pcD, opA: rdA, opB: rdB, imm: immD,
                  rs: rsD, rt: rtD, dest: destD};
        if (rst_i || stall) begin
            idEx.ctrl <= '0;
        end
    end

    // execute
    always_comb begin
        case (fwdA)
            FWD_MEM: opA = exMem.aluRes;
            FWD_WB:  opA = wbData;
            default: opA = idEx.opA;
        endcase
        case (fwdB)
            FWD_MEM: opB = exMem.aluRes;
            FWD_WB:  opB = wbData;
            default: opB = idEx.opB;
        endcase
    end

    assign aluB = idEx.ctrl.aluSrcImm ? idEx.imm : opB;

    aluUnit i_aluUnit (
        .a_i      (opA),
        .b_i      (aluB),
        .op_i     (idEx.ctrl.aluOp),
        .result_o (aluRes)
    );

    always_ff @(posedge clk_i) begin
        exMem <= '{ctrl: idEx.ctrl, pc: idEx.pc, aluRes: aluRes, storeData: opB,
                   dest: idEx.dest};
        if (rst_i) begin
            exMem.ctrl <= '0;
        end
    end

    // memory
    assign dataEn_o    = exMem.ctrl.memRead || exMem.ctrl.memWrite;
    assign dataWe_o    = exMem.ctrl.memWrite;
    assign dataAddr_o  = exMem.aluRes;
    assign dataWdata_o = exMem.storeData;

    always_ff @(posedge clk_i) begin
        memWb <= '{regWrite: exMem.ctrl.regWrite, memRead: exMem.ctrl.memRead,
                   pc: exMem.pc, aluRes: exMem.aluRes, dest: exMem.dest};
        if (rst_i) begin
            memWb.regWrite <= 1'b0;
            memWb.memRead  <= 1'b0;
        end
    end

    // write-back, load data arrives this cycle
    assign wbData   = memWb.memRead ? dataRdata_i : memWb.aluRes;
    assign wbEn_o   = memWb.regWrite;
    assign wbReg_o  = memWb.dest;
    assign wbData_o = wbData;
    assign wbPc_o   = memWb.pc;

endmodule

//--- verification/mipsCore_chk.sv
`timescale 1ns/1ps

module mipsCore_chk (
    input logic                   clk_i,
    input logic                   rst_i,
    input logic                   stall_i,
    input mips_isa_pkg::word_t    instrAddr_i,
    input logic                   wbEn_i,
    input mips_isa_pkg::regAddr_t wbReg_i,
    input logic                   dataEn_i,
    input logic                   dataWe_i
);
    int errCount = 0;

    // decoder drops writes to $zero
    wbNotZero: assert property (@(posedge clk_i) disable iff (rst_i)
        wbEn_i |-> wbReg_i != '0)
        else begin
            $error("write-back to register zero on the trace port");
            errCount++;
        end

    fetchAligned: assert property (@(posedge clk_i) disable iff (rst_i)
        instrAddr_i[1:0] == 2'b00)
        else begin
            $error("instrAddr_o is not word aligned");
            errCount++;
        end

    // fetch holds during a stall
    stallHoldsPc: assert property (@(posedge clk_i) disable iff (rst_i)
        stall_i |=> $stable(instrAddr_i))
        else begin
            $error("instrAddr_o moved while stalled");
            errCount++;
        end

    writeHasEnable: assert property (@(posedge clk_i) disable iff (rst_i)
        dataWe_i |-> dataEn_i)
        else begin
            $error("dataWe_o high without dataEn_o");
            errCount++;
        end

endmodule

//--- verification/mipsCore_tb.sv
`timescale 1ns/1ps

`include "mips_defines.svh"

module mipsCore_tb;
    import mips_isa_pkg::*;

    localparam int romWords = 64;
    localparam int ramWords = 64;

    logic     clk_i = 1'b0;
    logic     rst_i = 1'b1;
    word_t    instrAddr_o;
    word_t    instr_i;
    logic     dataEn_o;
    logic     dataWe_o;
    word_t    dataAddr_o;
    word_t    dataWdata_o;
    word_t    dataRdata_i = '0;
    logic     wbEn_o;
    regAddr_t wbReg_o;
    word_t    wbData_o;
    word_t    wbPc_o;

    word_t rom [romWords] = '{default: '0};
    word_t ram [ramWords] = '{default: '0};
    word_t rdWord = '0;

    word_t    prog [$];
    int       progTest [$];
    word_t    expPc [$];
    regAddr_t expReg [$];
    word_t    expVal [$];
    int       expTest [$];
    word_t    expStAddr [$];
    word_t    expStData [$];
    int       wbIdx = 0;
    int       stIdx = 0;
    int       errors = 0;
    int       seed = 32'h3042a67c;
    int       expCount [1:5] = '{default: 0};
    int       doneCount [1:5] = '{default: 0};
    int       testErrors [1:5] = '{default: 0};
    string    testName [1:5] = '{"reset", "alu forwarding", "load and store",
                                 "branches", "register zero"};

    mipsCore i_mipsCore (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .instrAddr_o (instrAddr_o),
        .instr_i     (instr_i),
        .dataEn_o    (dataEn_o),
        .dataWe_o    (dataWe_o),
        .dataAddr_o  (dataAddr_o),
        .dataWdata_o (dataWdata_o),
        .dataRdata_i (dataRdata_i),
        .wbEn_o      (wbEn_o),
        .wbReg_o     (wbReg_o),
        .wbData_o    (wbData_o),
        .wbPc_o      (wbPc_o)
    );

    bind mipsCore mipsCore_chk i_mipsCore_chk (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .stall_i     (stall),
        .instrAddr_i (instrAddr_o),
        .wbEn_i      (wbEn_o),
        .wbReg_i     (wbReg_o),
        .dataEn_i    (dataEn_o),
        .dataWe_i    (dataWe_o)
    );

    initial begin
        forever #4 clk_i = ~clk_i;
    end

    // instruction rom answers in the same cycle
    assign instr_i = (instrAddr_o < romWords * 4) ? rom[instrAddr_o[7:2]] : '0;

    // data ram, read data shows up one cycle later
    always @(posedge clk_i) begin
        if (!rst_i && dataEn_o && dataWe_o) begin
            checkStore();
            ram[dataAddr_o[7:2]] <= dataWdata_o;
        end
        if (!rst_i && dataEn_o && !dataWe_o) begin
            rdWord <= ram[dataAddr_o[7:2]];
        end
    end

    always @(negedge clk_i) begin
        dataRdata_i <= rdWord;
    end

    always @(posedge clk_i) begin
        if (!rst_i && wbEn_o) begin
            checkWriteBack();
        end
    end

    function automatic logic [15:0] randImm();
        return 16'($random(seed));
    endfunction

    function automatic word_t iType(input opcode_t op, input regAddr_t rs, input regAddr_t rt,
                                    input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t rType(input regAddr_t rs, input regAddr_t rt, input regAddr_t rd,
                                    input funct_t fn);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    task automatic emit(input word_t ins, input int t);
        prog.push_back(ins);
        progTest.push_back(t);
    endtask

    task automatic buildProgram();
        // dependent chain, both forwarding paths
        emit(iType(OP_ADDIU, 0, 1, randImm()), 2);
        emit(iType(OP_ADDIU, 1, 2, randImm()), 2);
        emit(rType(1, 2, 3, FN_ADDU), 2);
        emit(rType(3, 1, 4, FN_SUBU), 2);
        emit(rType(4, 3, 5, FN_AND), 2);
        emit(rType(5, 2, 6, FN_OR), 2);
        emit(rType(6, 4, 7, FN_SLT), 2);
        emit(iType(OP_ORI, 7, 8, randImm()), 2);
        emit(rType(8, 6, 9, FN_ADDU), 2);
        // stores, reloads and immediate use of load data
        emit(iType(OP_SW, 0, 9, 16'h0010), 3);
        emit(iType(OP_SW, 0, 4, 16'h0024), 3);
        emit(iType(OP_LW, 0, 10, 16'h0010), 3);
        emit(rType(10, 2, 11, FN_ADDU), 3);
        emit(iType(OP_LW, 0, 12, 16'h0024), 3);
        emit(rType(3, 12, 13, FN_SUBU), 3);
        // taken: $12 holds the stored $4
        emit(iType(OP_BEQ, 12, 4, 16'd3), 4);
        emit(iType(OP_ADDIU, 13, 15, randImm()), 4);
        emit(iType(OP_ADDIU, 0, 16, randImm()), 4);
        emit(iType(OP_ADDIU, 0, 17, randImm()), 4);
        emit(iType(OP_ADDIU, 15, 18, randImm()), 4);
        // not taken, operand still in flight
        emit(iType(OP_ORI, 0, 14, randImm() | 16'h0001), 4);
        emit(iType(OP_BEQ, 14, 0, 16'd2), 4);
        emit(iType(OP_ADDIU, 18, 19, randImm()), 4);
        emit(iType(OP_ADDIU, 19, 20, randImm()), 4);
        // $zero as destination, then as source
        emit(iType(OP_ADDIU, 1, 0, randImm()), 5);
        emit(rType(2, 3, 0, FN_OR), 5);
        emit(rType(0, 3, 21, FN_ADDU), 5);
        emit(rType(21, 0, 22, FN_SUBU), 5);
        emit(iType(OP_ORI, 0, 23, randImm()), 5);
    endtask

    // sequential model with one delay slot
    task automatic runReference();
        word_t    regs [`MIPS_NREG];
        word_t    mem [ramWords];
        word_t    pc;
        word_t    npc;
        word_t    nextNpc;
        word_t    ins;
        word_t    a;
        word_t    b;
        word_t    imm;
        word_t    res;
        word_t    addr;
        regAddr_t dest;
        logic     wr;
        int       t;
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        foreach (mem[i]) begin
            mem[i] = '0;
        end
        pc  = `MIPS_RESET_PC;
        npc = pc + 32'd4;
        while ((pc >> 2) < prog.size()) begin
            ins     = prog[pc >> 2];
            t       = progTest[pc >> 2];
            a       = regs[ins[25:21]];
            b       = regs[ins[20:16]];
            imm     = {{16{ins[15]}}, ins[15:0]};
            addr    = a + imm;
            nextNpc = npc + 32'd4;
            wr      = 1'b1;
            dest    = ins[20:16];
            res     = '0;
            case (ins[31:26])
                OP_RTYPE: begin
                    dest = ins[15:11];
                    case (ins[5:0])
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: res = a + imm;
                OP_ORI:   res = a | {16'b0, ins[15:0]};
                OP_LW:    res = mem[addr[7:2]];
                OP_SW: begin
                    wr = 1'b0;
                    mem[addr[7:2]] = b;
                    expStAddr.push_back(addr);
                    expStData.push_back(b);
                    expCount[t]++;
                end
                OP_BEQ: begin
                    wr = 1'b0;
                    if (a == b) begin
                        nextNpc = pc + 32'd4 + (imm << 2);
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && dest != '0) begin
                regs[dest] = res;
                expPc.push_back(pc);
                expReg.push_back(dest);
                expVal.push_back(res);
                expTest.push_back(t);
                expCount[t]++;
            end
            pc  = npc;
            npc = nextNpc;
        end
    endtask

    task automatic reportValue(input string name, input word_t expected, input word_t actual,
                               input int t);
        $display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        errors++;
        testErrors[t]++;
    endtask

    task automatic finishTest(input int t);
        $display("test %0d %s: %0d checks, %0d errors", t, testName[t], doneCount[t],
                 testErrors[t]);
    endtask

    task automatic countCheck(input int t);
        doneCount[t]++;
        if (doneCount[t] == expCount[t]) begin
            finishTest(t);
        end
    endtask

    task automatic checkWriteBack();
        int t;
        assert (wbIdx < expPc.size()) else begin
            $display("unexpected write-back at %0t ns to register %0d from pc %h",
                     $time, wbReg_o, wbPc_o);
            errors++;
        end
        if (wbIdx < expPc.size()) begin
            t = expTest[wbIdx];
            assert (wbPc_o == expPc[wbIdx]) else reportValue("wbPc_o", expPc[wbIdx], wbPc_o, t);
            assert (wbReg_o == expReg[wbIdx])
                else reportValue("wbReg_o", expReg[wbIdx], wbReg_o, t);
            assert (wbData_o == expVal[wbIdx])
                else reportValue("wbData_o", expVal[wbIdx], wbData_o, t);
            wbIdx++;
            countCheck(t);
        end
    endtask

    task automatic checkStore();
        assert (stIdx < expStAddr.size()) else begin
            $display("unexpected store at %0t ns to address %h", $time, dataAddr_o);
            errors++;
        end
        if (stIdx < expStAddr.size()) begin
            assert (dataAddr_o == expStAddr[stIdx])
                else reportValue("dataAddr_o", expStAddr[stIdx], dataAddr_o, 3);
            assert (dataWdata_o == expStData[stIdx])
                else reportValue("dataWdata_o", expStData[stIdx], dataWdata_o, 3);
            stIdx++;
            countCheck(3);
        end
    endtask

    initial begin
        int quiet;
        int totalErr;
        quiet = 0;
        buildProgram();
        foreach (prog[i]) begin
            rom[i] = prog[i];
        end
        runReference();
        repeat (3) @(negedge clk_i);
        rst_i = 1'b0;

        // nothing leaves the pipe until the first instruction reaches write-back
        @(posedge clk_i);
        assert (instrAddr_o == `MIPS_RESET_PC)
            else reportValue("instrAddr_o", `MIPS_RESET_PC, instrAddr_o, 1);
        while (!wbEn_o && quiet < 8) begin
            assert (!dataEn_o) else reportValue("dataEn_o", 32'd0, 32'(dataEn_o), 1);
            quiet++;
            @(posedge clk_i);
        end
        assert (quiet == 4) else reportValue("wbEn_o first cycle", 32'd4, 32'(quiet), 1);
        doneCount[1] = quiet + 2;
        finishTest(1);

        while (wbIdx < expPc.size() || stIdx < expStAddr.size()) begin
            @(posedge clk_i);
        end
        // trailing nops must stay silent
        repeat (10) @(posedge clk_i);
        totalErr = errors + i_mipsCore.i_mipsCore_chk.errCount;
        $display("write-backs %0d/%0d, stores %0d/%0d, errors %0d", wbIdx, expPc.size(),
                 stIdx, expStAddr.size(), totalErr);
        if (totalErr == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (!rst_i);
        repeat (prog.size() * 2 + 20) @(posedge clk_i);
        $display("timeout: the program did not finish within %0d cycles",
                 prog.size() * 2 + 20);
        $display("tests failed");
        $finish;
    end

endmodule

//--- compile.f
+incdir+include
source/mips_isa_pkg.sv
source/mips_pipe_pkg.sv
source/instrDecoder.sv
source/regFile.sv
source/aluUnit.sv
source/hazardUnit.sv
source/mipsCore.sv
verification/mipsCore_chk.sv
verification/mipsCore_tb.sv
